// File: eth_filter_pkg.sv
// udp flow filter definitions
package eth_filter_pkg;

	localparam int DATA_W = 64;
	localparam int KEEP_W = 8;

	// protocol fields, network byte order already swapped
	localparam logic [15:0] ETH_FTYPE_IP = 16'h0800;
	localparam logic [7:0]  IP_PROTO_UDP = 8'h11;

	localparam logic [3:0] VERDICT_DROP = 4'd1;

	localparam int CLASS_DELAY         = 4; // beats
	localparam int KEY_FIFO_DEPTH_BITS = 5;
	localparam int PKT_FIFO_DEPTH_BITS = 9;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [KEEP_W-1:0] keep_t;

	// {data, keep, last}
	typedef logic [DATA_W+KEEP_W:0] beat_t;

	typedef logic [95:0] flow_key_t;
	typedef logic [3:0]  verdict_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] port_t;
	typedef logic [31:0] pkt_cnt_t;
	typedef logic [9:0]  beat_idx_t;

	typedef enum logic [1:0] {
		IDLE,
		PASS,
		DROP
	} ctrl_state_t;

endpackage

// File: eth_rx_parser.sv
// receive header parser
module eth_rx_parser (
	input  logic                      clk156,
	input  logic                      eth_rst,
	input  logic                      rx_valid,
	input  eth_filter_pkg::data_t     rx_data,
	input  logic                      rx_last,
	output logic                      key_valid,
	output eth_filter_pkg::flow_key_t key,
	output logic                      known_valid,
	output logic                      frame_is_udp
);
	import eth_filter_pkg::*;

	beat_idx_t   rx_cnt;
	logic [15:0] ftype;
	logic [7:0]  ip_proto;
	ip_addr_t    src_ip;
	logic [15:0] dst_ip_hi;
	ip_addr_t    dst_ip;
	port_t       src_port;
	port_t       dst_port;
	logic        is_udp;

	// beat 4 fields, straight off the bus
	assign dst_ip   = {dst_ip_hi, rx_data[7:0], rx_data[15:8]};
	assign src_port = {rx_data[23:16], rx_data[31:24]};
	assign dst_port = {rx_data[39:32], rx_data[47:40]};

	assign is_udp       = (ftype == ETH_FTYPE_IP) && (ip_proto == IP_PROTO_UDP);
	assign frame_is_udp = is_udp; // sampled with known_valid

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			rx_cnt      <= '0;
			ftype       <= '0;
			ip_proto    <= '0;
			src_ip      <= '0;
			dst_ip_hi   <= '0;
			known_valid <= 1'b0;
			key_valid   <= 1'b0;
		end else begin
			known_valid <= rx_valid && (rx_cnt == 10'd2);
			key_valid   <= rx_valid && (rx_cnt == 10'd4) && is_udp;
			if (rx_valid) begin
				if (rx_last) begin
					rx_cnt    <= '0;
					ftype     <= '0;
					ip_proto  <= '0;
					src_ip    <= '0;
					dst_ip_hi <= '0;
				end else begin
					if (rx_cnt != '1)
						rx_cnt <= rx_cnt + 1'b1; // saturate on jumbo frames
					case (rx_cnt)
						10'd1: ftype <= {rx_data[39:32], rx_data[47:40]};
						10'd2: ip_proto <= rx_data[63:56];
						10'd3: begin
							src_ip    <= {rx_data[23:16], rx_data[31:24],
							              rx_data[39:32], rx_data[47:40]};
							dst_ip_hi <= {rx_data[55:48], rx_data[63:56]};
						end
						default: ;
					endcase
				end
			end
		end
	end

	// key word order matches the lookup engine
	always_ff @(posedge clk156) begin
		if (rx_valid && (rx_cnt == 10'd4))
			key <= {src_ip, dst_ip, dst_port, src_port};
	end

endmodule

// File: eth_class_delay.sv
// class delay line and steering
module eth_class_delay (
	input  logic                  clk156,
	input  logic                  eth_rst,
	input  logic                  rx_valid,
	input  eth_filter_pkg::data_t rx_data,
	input  eth_filter_pkg::keep_t rx_keep,
	input  logic                  rx_last,
	input  logic                  known_valid,
	input  logic                  frame_is_udp,
	output logic                  byp_push,
	output logic                  udp_push,
	output eth_filter_pkg::beat_t beat
);
	import eth_filter_pkg::*;

	logic [CLASS_DELAY-1:0] stg_vld;
	beat_t                  stg_beat [CLASS_DELAY];
	logic                   out_vld;
	logic                   cls_udp;  // class of frame leaving the line
	logic                   out_busy; // frame partly pushed out

	assign out_vld  = stg_vld[CLASS_DELAY-1];
	assign beat     = stg_beat[CLASS_DELAY-1];
	assign byp_push = out_vld && !cls_udp;
	assign udp_push = out_vld && cls_udp;

	always_ff @(posedge clk156) begin
		if (eth_rst)
			stg_vld <= '0;
		else
			stg_vld <= {stg_vld[CLASS_DELAY-2:0], rx_valid};
	end

	always_ff @(posedge clk156) begin
		stg_beat[0] <= {rx_data, rx_keep, rx_last};
		for (int i = 1; i < CLASS_DELAY; i++)
			stg_beat[i] <= stg_beat[i-1];
	end

	// next frame's class may land on the same cycle as our last beat
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			cls_udp  <= 1'b0;
			out_busy <= 1'b0;
		end else begin
			if (known_valid)
				cls_udp <= frame_is_udp;
			else if (out_vld && beat[0])
				cls_udp <= 1'b0; // short frames default to bypass
			if (out_vld)
				out_busy <= !beat[0];
		end
	end

	// class must be settled before a frame's first beat leaves
	a_class_in_time: assert property (@(posedge clk156) disable iff (eth_rst)
		known_valid |-> !out_busy || (out_vld && beat[0]));

endmodule

// File: eth_sync_fifo.sv
// first-word-fallthrough fifo
module eth_sync_fifo #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_BITS = 4
) (
	input  logic             clk156,
	input  logic             eth_rst,
	input  logic [WIDTH-1:0] din,
	input  logic             wr_en,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             full,
	output logic             empty
);

	logic [WIDTH-1:0]      mem [2**DEPTH_BITS];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;

	assign dout  = mem[rd_ptr]; // head visible without a read
	assign empty = (count == '0);
	assign full  = count[DEPTH_BITS];

	always_ff @(posedge clk156) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk156) disable iff (eth_rst)
		!(wr_en && full));
	a_no_underflow: assert property (@(posedge clk156) disable iff (eth_rst)
		!(rd_en && empty));

endmodule

// File: eth_verdict_ctrl.sv
// verdict release and discard control
module eth_verdict_ctrl (
	input  logic                     clk156,
	input  logic                     eth_rst,
	input  logic                     vfifo_empty,
	input  eth_filter_pkg::verdict_t vfifo_flag,
	output logic                     vfifo_pop,
	input  logic                     pkt_empty,
	input  eth_filter_pkg::beat_t    pkt_beat,
	output logic                     pkt_pop,
	output logic                     chk_valid,
	output eth_filter_pkg::beat_t    chk_beat,
	input  logic                     chk_ready,
	output eth_filter_pkg::pkt_cnt_t pass_count,
	output eth_filter_pkg::pkt_cnt_t drop_count
);
	import eth_filter_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        pkt_last;
	logic        frame_done;

	assign pkt_last   = pkt_beat[0];
	assign frame_done = pkt_pop && pkt_last;
	assign chk_beat   = pkt_beat; // head of udp buffer goes to the merge as is

	always_comb begin
		state_nxt = state;
		vfifo_pop = 1'b0;
		pkt_pop   = 1'b0;
		chk_valid = 1'b0;
		case (state)
			IDLE: begin
				if (!vfifo_empty) begin
					vfifo_pop = 1'b1;
					state_nxt = (vfifo_flag == VERDICT_DROP) ? DROP : PASS;
				end
			end
			PASS: begin
				chk_valid = !pkt_empty; // frame tail may still be arriving
				pkt_pop   = chk_valid && chk_ready;
				if (pkt_pop && pkt_last)
					state_nxt = IDLE;
			end
			DROP: begin
				pkt_pop = !pkt_empty; // one beat per cycle
				if (pkt_pop && pkt_last)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			state      <= IDLE;
			pass_count <= '0;
			drop_count <= '0;
		end else begin
			state <= state_nxt;
			if (frame_done && (state == PASS))
				pass_count <= pass_count + 1'b1;
			if (frame_done && (state == DROP))
				drop_count <= drop_count + 1'b1;
		end
	end

endmodule

// File: eth_tx_merge.sv
// packet-locked tx arbiter
module eth_tx_merge (
	input  logic                  clk156,
	input  logic                  eth_rst,
	input  logic                  byp_empty,
	input  eth_filter_pkg::beat_t byp_beat,
	output logic                  byp_pop,
	input  logic                  chk_valid,
	input  eth_filter_pkg::beat_t chk_beat,
	output logic                  chk_ready,
	output logic                  tx_valid,
	output eth_filter_pkg::data_t tx_data,
	output eth_filter_pkg::keep_t tx_keep,
	output logic                  tx_last,
	input  logic                  tx_ready
);
	import eth_filter_pkg::*;

	logic  locked;   // grant held until last beat goes out
	logic  lock_chk;
	logic  pick_chk;
	beat_t sel_beat;

	// bypass wins when nothing is locked
	assign pick_chk = locked ? lock_chk : byp_empty;

	assign sel_beat = pick_chk ? chk_beat : byp_beat;
	assign tx_valid = pick_chk ? chk_valid : !byp_empty;
	assign tx_data  = sel_beat[DATA_W+KEEP_W:KEEP_W+1];
	assign tx_keep  = sel_beat[KEEP_W:1];
	assign tx_last  = sel_beat[0];

	assign byp_pop   = tx_valid && tx_ready && !pick_chk;
	assign chk_ready = tx_ready && pick_chk;

	// lock as soon as a beat is offered, so a stalled beat cannot be swapped
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			locked   <= 1'b0;
			lock_chk <= 1'b0;
		end else if (tx_valid) begin
			if (tx_ready && tx_last) begin
				locked <= 1'b0;
			end else begin
				locked   <= 1'b1;
				lock_chk <= pick_chk;
			end
		end
	end

	a_tx_hold: assert property (@(posedge clk156) disable iff (eth_rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last));

endmodule

// File: eth_udp_filter.sv
// udp flow filter top
module eth_udp_filter (
	input  logic                      clk156,
	input  logic                      eth_rst,
	input  logic                      rx_valid,
	input  eth_filter_pkg::data_t     rx_data,
	input  eth_filter_pkg::keep_t     rx_keep,
	input  logic                      rx_last,
	output logic                      lookup_valid,
	output eth_filter_pkg::flow_key_t lookup_key,
	input  logic                      lookup_ready,
	input  logic                      result_valid,
	input  eth_filter_pkg::verdict_t  result_flag,
	output logic                      tx_valid,
	output eth_filter_pkg::data_t     tx_data,
	output eth_filter_pkg::keep_t     tx_keep,
	output logic                      tx_last,
	input  logic                      tx_ready,
	output eth_filter_pkg::pkt_cnt_t  pass_count,
	output eth_filter_pkg::pkt_cnt_t  drop_count
);
	import eth_filter_pkg::*;

	logic      key_valid;
	flow_key_t key;
	logic      known_valid;
	logic      frame_is_udp;
	logic      byp_push;
	logic      udp_push;
	beat_t     dly_beat;
	logic      key_empty;
	logic      vfifo_empty;
	verdict_t  vfifo_flag;
	logic      vfifo_pop;
	logic      byp_empty;
	beat_t     byp_beat;
	logic      byp_pop;
	logic      pkt_empty;
	beat_t     pkt_beat;
	logic      pkt_pop;
	logic      chk_valid;
	beat_t     chk_beat;
	logic      chk_ready;

	assign lookup_valid = !key_empty && lookup_ready;

	eth_rx_parser u_parser (
		.clk156, .eth_rst, .rx_valid, .rx_data, .rx_last,
		.key_valid, .key, .known_valid, .frame_is_udp
	);

	eth_class_delay u_delay (
		.clk156, .eth_rst, .rx_valid, .rx_data, .rx_keep, .rx_last,
		.known_valid, .frame_is_udp, .byp_push, .udp_push, .beat(dly_beat)
	);

	eth_sync_fifo #(.WIDTH($bits(flow_key_t)), .DEPTH_BITS(KEY_FIFO_DEPTH_BITS)) u_key_fifo (
		.clk156, .eth_rst, .din(key), .wr_en(key_valid), .rd_en(lookup_valid),
		.dout(lookup_key), .full(), .empty(key_empty)
	);

	eth_sync_fifo #(.WIDTH($bits(verdict_t)), .DEPTH_BITS(KEY_FIFO_DEPTH_BITS)) u_vfifo (
		.clk156, .eth_rst, .din(result_flag), .wr_en(result_valid), .rd_en(vfifo_pop),
		.dout(vfifo_flag), .full(), .empty(vfifo_empty)
	);

	eth_sync_fifo #(.WIDTH($bits(beat_t)), .DEPTH_BITS(PKT_FIFO_DEPTH_BITS)) u_byp_fifo (
		.clk156, .eth_rst, .din(dly_beat), .wr_en(byp_push), .rd_en(byp_pop),
		.dout(byp_beat), .full(), .empty(byp_empty)
	);

	eth_sync_fifo #(.WIDTH($bits(beat_t)), .DEPTH_BITS(PKT_FIFO_DEPTH_BITS)) u_pkt_fifo (
		.clk156, .eth_rst, .din(dly_beat), .wr_en(udp_push), .rd_en(pkt_pop),
		.dout(pkt_beat), .full(), .empty(pkt_empty)
	);

	eth_verdict_ctrl u_ctrl (
		.clk156, .eth_rst, .vfifo_empty, .vfifo_flag, .vfifo_pop,
		.pkt_empty, .pkt_beat, .pkt_pop, .chk_valid, .chk_beat, .chk_ready,
		.pass_count, .drop_count
	);

	eth_tx_merge u_merge (
		.clk156, .eth_rst, .byp_empty, .byp_beat, .byp_pop,
		.chk_valid, .chk_beat, .chk_ready,
		.tx_valid, .tx_data, .tx_keep, .tx_last, .tx_ready
	);

endmodule

// File: tb_eth_udp_filter.sv
// udp flow filter testbench
module tb_eth_udp_filter;
	import eth_filter_pkg::*;

	localparam int TIMEOUT = 2000; // cycles per wait

	logic      clk156 = 1'b0;
	logic      eth_rst, rx_valid, rx_last, lookup_valid, lookup_ready;
	logic      result_valid, tx_valid, tx_last, tx_ready;
	data_t     rx_data, tx_data, held_data;
	keep_t     rx_keep, tx_keep, last_keep;
	flow_key_t lookup_key, got_key;
	verdict_t  result_flag, verdict;
	pkt_cnt_t  pass_count, drop_count, n_pass, n_drop;

	// current trace record
	logic [15:0] ftype;
	logic [7:0]  proto;
	ip_addr_t    src_ip, dst_ip;
	port_t       src_port, dst_port;
	logic [31:0] tag;
	int          beats = 0;
	int          outcome; // 0 bypass, 1 pass, 2 drop

	integer seed = 32'he93e;
	int     errors = 0;
	int     tx_seen = 0;
	int     keys_seen = 0;
	int     reply_timer = 0;
	logic   hold_check = 1'b0;
	data_t  exp_data [64];
	keep_t  exp_keep [64];

	eth_udp_filter dut (.*);

	always #2 clk156 = ~clk156;

	// byte i of the frame with big-endian header fields
	function automatic logic [7:0] frame_byte(int i);
		logic [7:0] b;
		b = tag[8*(i%4) +: 8] ^ i[7:0]; // payload and filler
		if (i == 12 || i == 13)
			b = ftype[8*(13-i) +: 8];
		else if (i == 23)
			b = proto;
		else if (i >= 26 && i <= 29)
			b = src_ip[8*(29-i) +: 8];
		else if (i >= 30 && i <= 33)
			b = dst_ip[8*(33-i) +: 8];
		else if (i == 34 || i == 35)
			b = src_port[8*(35-i) +: 8];
		else if (i == 36 || i == 37)
			b = dst_port[8*(37-i) +: 8];
		return b;
	endfunction

	task automatic check_counts(pkt_cnt_t exp_pass, pkt_cnt_t exp_drop);
		if (pass_count !== exp_pass) begin
			$display("Fail t=%0t pass_count got %0d expected %0d", $time, pass_count, exp_pass);
			errors++;
		end
		if (drop_count !== exp_drop) begin
			$display("Fail t=%0t drop_count got %0d expected %0d", $time, drop_count, exp_drop);
			errors++;
		end
	endtask

	// lookup engine model and random back-pressure
	always @(posedge clk156) begin
		#1;
		tx_ready     = ($random(seed) & 3) != 0;
		lookup_ready = ($random(seed) & 1) != 0;
		result_valid = 1'b0;
		if (reply_timer > 0) begin
			reply_timer = reply_timer - 1;
			if (reply_timer == 0) begin
				result_valid = 1'b1;
				result_flag  = verdict;
			end
		end
	end

	// tx and lookup monitor sampled mid-cycle
	always @(negedge clk156) begin
		if (!eth_rst) begin
			if (hold_check && tx_valid !== 1'b1) begin
				$display("Fail t=%0t tx_valid got %b expected 1 while stalled",
					$time, tx_valid);
				errors++;
			end else if (hold_check && tx_data !== held_data) begin
				$display("Fail t=%0t tx_data got %h expected %h while stalled",
					$time, tx_data, held_data);
				errors++;
			end
			hold_check = tx_valid && !tx_ready;
			held_data  = tx_data;
			if (tx_valid && tx_ready) begin
				if (tx_seen >= beats) begin
					$display("unexpected extra tx beat at t=%0t", $time);
					errors++;
				end else if (tx_data !== exp_data[tx_seen] || tx_keep !== exp_keep[tx_seen]
					|| tx_last !== (tx_seen == beats - 1)) begin
					$display("Fail t=%0t tx_data/keep/last got %h/%h/%b expected %h/%h/%b",
						$time, tx_data, tx_keep, tx_last, exp_data[tx_seen],
						exp_keep[tx_seen], tx_seen == beats - 1);
					errors++;
				end
				tx_seen++;
			end
			if (lookup_valid) begin
				keys_seen++;
				got_key     = lookup_key;
				reply_timer = 3;
			end
		end
	end

	initial begin
		int    fd, n, cyc, frame_err, tests, failed;
		string line;
		logic  timed_out;
		logic  is_udp;
		eth_rst      = 1'b1;
		rx_valid     = 1'b0;
		rx_data      = '0;
		rx_keep      = '0;
		rx_last      = 1'b0;
		lookup_ready = 1'b0;
		result_valid = 1'b0;
		result_flag  = '0;
		tx_ready     = 1'b0;
		n_pass       = '0;
		n_drop       = '0;
		timed_out    = 1'b0;
		tests        = 1;
		failed       = 0;
		repeat (8) @(posedge clk156);
		#1 eth_rst = 1'b0;

		// lookup_valid only shows the key FIFO while lookup_ready is high
		for (cyc = 0; cyc < TIMEOUT; cyc++) begin
			@(negedge clk156);
			if (lookup_ready)
				break;
		end
		if (cyc == TIMEOUT) begin
			$display("timeout: lookup_ready never went high after reset");
			errors++;
		end
		if (tx_valid !== 1'b0 || lookup_valid !== 1'b0) begin
			$display("Fail t=%0t tx_valid/lookup_valid got %b/%b expected 0/0",
				$time, tx_valid, lookup_valid);
			errors++;
		end
		check_counts(n_pass, n_drop);
		if (errors != 0)
			failed++;
		$display("test 0 reset: %s", (errors == 0) ? "ok" : "errors");

		fd = $fopen("eth_filter_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open eth_filter_trace.txt");
			errors++;
		end else begin
			while (!timed_out && $fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%h %h %h %h %h %h %h %d %h %h %d", ftype, proto, src_ip,
					dst_ip, src_port, dst_port, tag, beats, last_keep, verdict, outcome);
				if (n != 11 || beats < 6 || beats > 64) begin
					$display("bad trace line: %s", line);
					errors++;
					continue;
				end
				frame_err = errors;
				is_udp    = (ftype == 16'h0800) && (proto == 8'h11);
				for (int b = 0; b < beats; b++) begin
					for (int k = 0; k < 8; k++)
						exp_data[b][8*k +: 8] = frame_byte(8*b + k);
					exp_keep[b] = (b == beats - 1) ? last_keep : 8'hff;
				end
				tx_seen   = 0;
				keys_seen = 0;
				for (int b = 0; b < beats; b++) begin // back to back as on the wire
					@(posedge clk156);
					#1;
					rx_valid = 1'b1;
					rx_data  = exp_data[b];
					rx_keep  = exp_keep[b];
					rx_last  = (b == beats - 1);
				end
				@(posedge clk156);
				#1;
				rx_valid = 1'b0;
				rx_last  = 1'b0;
				if (outcome == 2)
					n_drop++;
				else if (outcome == 1)
					n_pass++;

				for (cyc = 0; cyc < TIMEOUT; cyc++) begin
					if ((outcome == 2) ? (drop_count == n_drop) : (tx_seen >= beats))
						break;
					@(posedge clk156);
					#1;
				end
				if (cyc == TIMEOUT) begin
					$display("timeout: frame tag %h never came out or was never dropped", tag);
					errors++;
					timed_out = 1'b1;
				end
				repeat (12) begin // quiet period to catch stray beats and keys
					@(posedge clk156);
					#1;
				end

				if (tx_seen != ((outcome == 2) ? 0 : beats)) begin
					$display("Fail t=%0t tx beats got %0d expected %0d", $time, tx_seen,
						(outcome == 2) ? 0 : beats);
					errors++;
				end
				if (keys_seen != (is_udp ? 1 : 0)) begin
					$display("Fail t=%0t lookup count got %0d expected %0d", $time, keys_seen,
						is_udp ? 1 : 0);
					errors++;
				end
				if (is_udp && got_key !== {src_ip, dst_ip, dst_port, src_port}) begin
					$display("Fail t=%0t lookup_key got %h expected %h", $time, got_key,
						{src_ip, dst_ip, dst_port, src_port});
					errors++;
				end
				check_counts(n_pass, n_drop);
				tests++;
				if (errors != frame_err)
					failed++;
				$display("test %0d tag %h %s: %s", tests - 1, tag,
					(outcome == 2) ? "drop" : (outcome == 1) ? "pass" : "bypass",
					(errors == frame_err) ? "ok" : "errors");
			end
			$fclose(fd);
		end

		$display("tests %0d failed %0d errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: verilog.f
eth_filter_pkg.sv
eth_rx_parser.sv
eth_class_delay.sv
eth_sync_fifo.sv
eth_verdict_ctrl.sv
eth_tx_merge.sv
eth_udp_filter.sv
tb_eth_udp_filter.sv

// File: run_sim.sh
#!/bin/sh
# build and run the udp filter testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_eth_udp_filter \
	-Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
	exit 0
fi
exit 1

// File: eth_filter_trace.txt
# ftype proto src_ip dst_ip src_port dst_port tag beats last_keep verdict outcome
# hex fields except beats and outcome (decimal); outcome 0 bypass, 1 pass, 2 drop
0800 11 0a000001 0a000002 1f90 0035 11110001 8 ff 0 1
0800 11 c0a80105 c0a80a0a 04d2 1388 11110002 6 0f 1 2
0800 06 0a000003 0a000004 c350 0050 22220003 7 ff 0 0
86dd 11 00000000 00000000 0000 0000 22220004 9 3f 0 0
0806 00 00000000 00000000 0000 0000 22220005 6 ff 0 0
0800 11 ac100001 ac100002 ea60 01bb 11110006 12 01 2 1
0800 11 ac100003 ac100004 ea61 01bb 11110007 10 ff 1 2
0800 11 08080808 0a0a0a0a 0035 d431 11110008 6 ff f 1
0800 01 0a000005 0a000006 0000 0000 22220009 6 ff 0 0
0800 11 7f000001 7f000001 ffff 0001 1111000a 16 7f 1 2
0800 11 01020304 05060708 1234 5678 1111000b 7 03 3 1
0800 06 0a000007 0a000008 0016 e000 2222000c 20 ff 1 0
0800 11 e0000001 0a000009 2710 2711 1111000d 8 ff 1 2
0800 11 0a00000a 0a00000b 2712 2713 1111000e 9 1f 0 1
0806 00 00000000 00000000 0000 0000 2222000f 6 01 0 0
0800 11 c6336401 c6336402 0400 0401 11110010 30 ff 4 1
